/* verilog/sdr_ctrl_pkg.sv */
package sdr_ctrl_pkg;

   // requester ports
   localparam int NUM_PORTS = 4;
   localparam int PORT_W = $clog2(NUM_PORTS);

   // sdram geometry, column counts 32-bit words
   localparam int BA_W = 2;
   localparam int ROW_W = 13;
   localparam int COL_W = 8;
   localparam int ADR_W = BA_W + ROW_W + COL_W;
   localparam int DQ_W = 16;
   localparam int DQM_W = DQ_W / 8;
   localparam int WORD_W = 2 * DQ_W;

   // timing in sdram_clk cycles
   localparam int CAS_LAT = 2;
   localparam int T_RCD = 2;
   localparam int T_RP = 2;
   localparam int T_RFC = 4;
   localparam int WAIT_W = $clog2(T_RFC + 1);

   // short refresh interval for simulation
   localparam int REF_INTERVAL = 64;
   localparam int REF_W = $clog2(REF_INTERVAL);

   // read command to data at the port, two extra for the capture stages
   localparam int RD_DELAY = CAS_LAT + 2;

   typedef logic [NUM_PORTS-1:0] port_sel_t;
   typedef logic [ADR_W-1:0] word_adr_t;
   typedef logic [WORD_W-1:0] word_t;
   typedef logic [WORD_W/8-1:0] bsel_t;

   // {ras, cas, we} as driven on the pads
   typedef enum logic [2:0] {
      cmd_nop          = 3'b111,
      cmd_active       = 3'b011,
      cmd_read         = 3'b101,
      cmd_write        = 3'b100,
      cmd_precharge    = 3'b010,
      cmd_auto_refresh = 3'b001
   } cmd_t;

endpackage

/* verilog/port_arbiter.sv */
`timescale 1ns/1ps

module port_arbiter (
   input  logic                                           sdram_clk,
   input  logic                                           sdram_rst,
   input  sdr_ctrl_pkg::port_sel_t                        req_i,
   input  logic [sdr_ctrl_pkg::NUM_PORTS-1:0]             we_i,
   input  sdr_ctrl_pkg::word_adr_t [sdr_ctrl_pkg::NUM_PORTS-1:0] adr_i,
   input  sdr_ctrl_pkg::word_t [sdr_ctrl_pkg::NUM_PORTS-1:0]     wdat_i,
   input  sdr_ctrl_pkg::bsel_t [sdr_ctrl_pkg::NUM_PORTS-1:0]     sel_i,
   input  logic                                           idle_i,
   output sdr_ctrl_pkg::port_sel_t                        grant_o,
   output logic                                           pending_o,
   output logic                                           g_we_o,
   output sdr_ctrl_pkg::word_adr_t                        g_adr_o,
   output sdr_ctrl_pkg::word_t                            g_wdat_o,
   output sdr_ctrl_pkg::bsel_t                            g_sel_o
);
   import sdr_ctrl_pkg::*;

   port_sel_t         grant_nxt;
   logic [PORT_W-1:0] idx;

   // lowest index wins, so scan from the top down
   always_comb begin
      grant_nxt = '0;
      idx = '0;
      for (int n = NUM_PORTS - 1; n >= 0; n--) begin
         if (req_i[n]) begin
            grant_nxt = '0;
            grant_nxt[n] = 1'b1;
            idx = PORT_W'(n);
         end
      end
   end

   // selection only moves while the command fsm sits in idle
   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         grant_o <= '0;
         g_we_o <= 1'b0;
      end else if (idle_i) begin
         grant_o <= grant_nxt;
         g_we_o <= we_i[idx];
      end
   end

   always_ff @(posedge sdram_clk) begin
      if (idle_i) begin
         g_adr_o <= adr_i[idx];
         g_wdat_o <= wdat_i[idx];
         g_sel_o <= sel_i[idx];
      end
   end

   assign pending_o = |grant_o;

endmodule

/* verilog/refresh_timer.sv */
`timescale 1ns/1ps

module refresh_timer (
   input  logic sdram_clk,
   input  logic sdram_rst,
   input  logic aref_i,
   output logic refresh_req_o
);
   import sdr_ctrl_pkg::*;

   logic [REF_W-1:0] ref_cnt;
   logic             ref_wrap;

   assign ref_wrap = (ref_cnt == REF_W'(REF_INTERVAL - 1));

   // free running interval counter
   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         ref_cnt <= '0;
      end else if (ref_wrap) begin
         ref_cnt <= '0;
      end else begin
         ref_cnt <= ref_cnt + 1'b1;
      end
   end

   // sticky until the fsm issues auto refresh
   // a wrap in the same cycle keeps it set
   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         refresh_req_o <= 1'b0;
      end else if (ref_wrap) begin
         refresh_req_o <= 1'b1;
      end else if (aref_i) begin
         refresh_req_o <= 1'b0;
      end
   end

endmodule

/* verilog/sdr_cmd_fsm.sv */
`timescale 1ns/1ps

module sdr_cmd_fsm (
   input  logic                            sdram_clk,
   input  logic                            sdram_rst,
   input  logic                            pending_i,
   input  logic                            we_i,
   input  sdr_ctrl_pkg::word_adr_t         adr_i,
   input  logic                            refresh_req_i,
   output logic                            idle_o,
   output sdr_ctrl_pkg::cmd_t              cmd_o,
   output logic [sdr_ctrl_pkg::BA_W-1:0]   ba_o,
   output logic [sdr_ctrl_pkg::ROW_W-1:0]  a_o,
   output logic                            aref_o,
   output logic                            cmd_read_o,
   output logic                            write_ack_o,
   output logic                            dq_oe_o,
   output logic                            second_beat_o
);
   import sdr_ctrl_pkg::*;

   typedef enum logic [3:0] {
      st_idle,
      st_aref,
      st_rfc,
      st_act,
      st_rcd,
      st_wr,
      st_wr2,
      st_rd,
      st_rd_nop,
      st_pre,
      st_rp
   } state_t;

   state_t            state;
   state_t            state_nxt;
   logic [WAIT_W-1:0] wait_cnt;
   logic [WAIT_W-1:0] wait_cnt_nxt;
   logic              idle_q;
   logic [BA_W-1:0]   bank;
   logic [ROW_W-1:0]  row;
   logic [COL_W-1:0]  col;

   assign {bank, row, col} = adr_i;

   always_comb begin
      state_nxt = state;
      wait_cnt_nxt = wait_cnt;
      case (state)
         // first idle cycle lets the arbiter take a fresh sample
         st_idle: begin
            if (idle_q) begin
               if (refresh_req_i) begin
                  state_nxt = st_aref;
               end else if (pending_i) begin
                  state_nxt = st_act;
               end
            end
         end
         st_aref: begin
            state_nxt = st_rfc;
            wait_cnt_nxt = WAIT_W'(T_RFC - 1);
         end
         st_rfc: begin
            if (wait_cnt == '0) begin
               state_nxt = st_idle;
            end else begin
               wait_cnt_nxt = wait_cnt - 1'b1;
            end
         end
         st_act: begin
            state_nxt = st_rcd;
            wait_cnt_nxt = WAIT_W'(T_RCD - 1);
         end
         st_rcd: begin
            if (wait_cnt == '0) begin
               state_nxt = we_i ? st_wr : st_rd;
            end else begin
               wait_cnt_nxt = wait_cnt - 1'b1;
            end
         end
         st_wr:     state_nxt = st_wr2;
         st_wr2:    state_nxt = st_pre;
         st_rd:     state_nxt = st_rd_nop;
         st_rd_nop: state_nxt = st_pre;
         st_pre: begin
            state_nxt = st_rp;
            wait_cnt_nxt = WAIT_W'(T_RP - 1);
         end
         st_rp: begin
            if (wait_cnt == '0) begin
               state_nxt = st_idle;
            end else begin
               wait_cnt_nxt = wait_cnt - 1'b1;
            end
         end
         default: state_nxt = st_idle;
      endcase
   end

   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         state <= st_idle;
         wait_cnt <= '0;
         idle_q <= 1'b0;
      end else begin
         state <= state_nxt;
         wait_cnt <= wait_cnt_nxt;
         idle_q <= (state == st_idle);
      end
   end

   // pad command decode, burst length two so the second beat is a nop
   always_comb begin
      cmd_o = cmd_nop;
      ba_o = '0;
      a_o = '0;
      case (state)
         st_aref: cmd_o = cmd_auto_refresh;
         st_act: begin
            cmd_o = cmd_active;
            ba_o = bank;
            a_o = row;
         end
         st_wr: begin
            cmd_o = cmd_write;
            ba_o = bank;
            a_o = ROW_W'({col, 1'b0});
         end
         st_rd: begin
            cmd_o = cmd_read;
            ba_o = bank;
            a_o = ROW_W'({col, 1'b0});
         end
         st_pre: begin
            cmd_o = cmd_precharge;
            // a10 high closes all banks
            a_o[10] = 1'b1;
         end
         default: cmd_o = cmd_nop;
      endcase
   end

   assign idle_o = (state == st_idle);
   assign aref_o = (state == st_aref);
   assign cmd_read_o = (state == st_rd);
   assign write_ack_o = (state == st_pre) && we_i;
   assign dq_oe_o = (state == st_wr) || (state == st_wr2);
   assign second_beat_o = (state == st_wr);

endmodule

/* verilog/latency_delay.sv */
`timescale 1ns/1ps

module latency_delay #(
   parameter type T = logic,
   parameter int DEPTH = 1
) (
   input  logic sdram_clk,
   input  logic sdram_rst,
   input  T     d_i,
   output T     q_o
);

   T sr [DEPTH];

   // stage 0 takes the input, the last stage is the output
   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         for (int i = 0; i < DEPTH; i++) begin
            sr[i] <= '0;
         end
      end else begin
         sr[0] <= d_i;
         for (int i = 1; i < DEPTH; i++) begin
            sr[i] <= sr[i-1];
         end
      end
   end

   assign q_o = sr[DEPTH-1];

endmodule

/* verilog/sdr_data_path.sv */
`timescale 1ns/1ps

module sdr_data_path (
   input  logic                            sdram_clk,
   input  logic                            sdram_rst,
   input  sdr_ctrl_pkg::word_t             wdat_i,
   input  sdr_ctrl_pkg::bsel_t             sel_i,
   input  logic                            second_beat_i,
   input  logic [sdr_ctrl_pkg::DQ_W-1:0]   dq_i,
   output logic [sdr_ctrl_pkg::DQ_W-1:0]   dq_o,
   output logic [sdr_ctrl_pkg::DQM_W-1:0]  dqm_o,
   output sdr_ctrl_pkg::word_t             rdat_o
);
   import sdr_ctrl_pkg::*;

   logic [DQ_W-1:0]  hold_dat;
   logic [DQM_W-1:0] hold_sel;
   logic [DQ_W-1:0]  dq_i_reg;
   logic [DQ_W-1:0]  dq_i_tmp_reg;

   // low half and its selects, waiting for the second beat
   always_ff @(posedge sdram_clk) begin
      hold_dat <= wdat_i[DQ_W-1:0];
      hold_sel <= sel_i[DQM_W-1:0];
   end

   // high half first, the held low half on the second beat
   always_ff @(posedge sdram_clk) begin
      if (second_beat_i) begin
         dq_o <= hold_dat;
      end else begin
         dq_o <= wdat_i[WORD_W-1:DQ_W];
      end
   end

   // dqm is active high mask, so the inverse of the byte selects
   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         dqm_o <= '0;
      end else if (second_beat_i) begin
         dqm_o <= ~hold_sel;
      end else begin
         dqm_o <= ~sel_i[WORD_W/8-1:DQM_W];
      end
   end

   // two capture stages, earlier beat ends up in the older register
   always_ff @(posedge sdram_clk) begin
      dq_i_reg <= dq_i;
      dq_i_tmp_reg <= dq_i_reg;
   end

   assign rdat_o = {dq_i_tmp_reg, dq_i_reg};

endmodule

/* verilog/sdr_ctrl_top.sv */
`timescale 1ns/1ps

module sdr_ctrl_top (
   input  logic                                           sdram_clk,
   input  logic                                           sdram_rst,
   input  sdr_ctrl_pkg::port_sel_t                        req_i,
   input  logic [sdr_ctrl_pkg::NUM_PORTS-1:0]             we_i,
   input  sdr_ctrl_pkg::word_adr_t [sdr_ctrl_pkg::NUM_PORTS-1:0] adr_i,
   input  sdr_ctrl_pkg::word_t [sdr_ctrl_pkg::NUM_PORTS-1:0]     wdat_i,
   input  sdr_ctrl_pkg::bsel_t [sdr_ctrl_pkg::NUM_PORTS-1:0]     sel_i,
   output sdr_ctrl_pkg::port_sel_t                        ack_o,
   output sdr_ctrl_pkg::word_t                            rdat_o,
   output logic [sdr_ctrl_pkg::BA_W-1:0]                  ba_pad_o,
   output logic [sdr_ctrl_pkg::ROW_W-1:0]                 a_pad_o,
   output logic                                           cs_n_pad_o,
   output logic                                           ras_pad_o,
   output logic                                           cas_pad_o,
   output logic                                           we_pad_o,
   output logic                                           cke_pad_o,
   output logic [sdr_ctrl_pkg::DQM_W-1:0]                 dqm_pad_o,
   output logic [sdr_ctrl_pkg::DQ_W-1:0]                  dq_o,
   input  logic [sdr_ctrl_pkg::DQ_W-1:0]                  dq_i,
   output logic                                           dq_oe_o
);
   import sdr_ctrl_pkg::*;

   port_sel_t grant;
   port_sel_t grant_dly;
   logic      pending;
   logic      g_we;
   word_adr_t g_adr;
   word_t     g_wdat;
   bsel_t     g_sel;
   bsel_t     dp_sel;
   logic      idle;
   logic      refresh_req;
   logic      aref;
   cmd_t      cmd;
   logic      cmd_read;
   logic      rd_strobe_dly;
   logic      write_ack;
   logic      second_beat;

   port_arbiter port_arbiter_inst (
      .sdram_clk (sdram_clk),
      .sdram_rst (sdram_rst),
      .req_i     (req_i),
      .we_i      (we_i),
      .adr_i     (adr_i),
      .wdat_i    (wdat_i),
      .sel_i     (sel_i),
      .idle_i    (idle),
      .grant_o   (grant),
      .pending_o (pending),
      .g_we_o    (g_we),
      .g_adr_o   (g_adr),
      .g_wdat_o  (g_wdat),
      .g_sel_o   (g_sel)
   );

   refresh_timer refresh_timer_inst (
      .sdram_clk     (sdram_clk),
      .sdram_rst     (sdram_rst),
      .aref_i        (aref),
      .refresh_req_o (refresh_req)
   );

   sdr_cmd_fsm sdr_cmd_fsm_inst (
      .sdram_clk     (sdram_clk),
      .sdram_rst     (sdram_rst),
      .pending_i     (pending),
      .we_i          (g_we),
      .adr_i         (g_adr),
      .refresh_req_i (refresh_req),
      .idle_o        (idle),
      .cmd_o         (cmd),
      .ba_o          (ba_pad_o),
      .a_o           (a_pad_o),
      .aref_o        (aref),
      .cmd_read_o    (cmd_read),
      .write_ack_o   (write_ack),
      .dq_oe_o       (dq_oe_o),
      .second_beat_o (second_beat)
   );

   // grant and read strobe follow the read data through cas latency and capture
   latency_delay #(.T(port_sel_t), .DEPTH(RD_DELAY)) grant_delay_inst (
      .sdram_clk (sdram_clk),
      .sdram_rst (sdram_rst),
      .d_i       (grant),
      .q_o       (grant_dly)
   );

   latency_delay #(.T(logic), .DEPTH(RD_DELAY)) read_delay_inst (
      .sdram_clk (sdram_clk),
      .sdram_rst (sdram_rst),
      .d_i       (cmd_read),
      .q_o       (rd_strobe_dly)
   );

   // reads keep dqm low for both beats
   assign dp_sel = g_we ? g_sel : '1;

   sdr_data_path sdr_data_path_inst (
      .sdram_clk     (sdram_clk),
      .sdram_rst     (sdram_rst),
      .wdat_i        (g_wdat),
      .sel_i         (dp_sel),
      .second_beat_i (second_beat),
      .dq_i          (dq_i),
      .dq_o          (dq_o),
      .dqm_o         (dqm_pad_o),
      .rdat_o        (rdat_o)
   );

   assign {ras_pad_o, cas_pad_o, we_pad_o} = cmd;
   assign cs_n_pad_o = 1'b0;
   assign cke_pad_o = 1'b1;

   assign ack_o = (grant_dly & {NUM_PORTS{rd_strobe_dly}}) | (grant & {NUM_PORTS{write_ack}});

endmodule

/* bench/sdr_ctrl_assert.sv */
`timescale 1ns/1ps

module sdr_ctrl_assert (
   input logic                    sdram_clk,
   input logic                    sdram_rst,
   input sdr_ctrl_pkg::port_sel_t req_i,
   input sdr_ctrl_pkg::port_sel_t ack_i,
   input logic                    ras_i,
   input logic                    cas_i,
   input logic                    we_i,
   input logic                    dq_oe_i,
   input logic                    refresh_req_i,
   input logic                    aref_i
);
   import sdr_ctrl_pkg::*;

   logic [REF_W:0] ref_wait;

   // cycles a refresh request has been left waiting
   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         ref_wait <= '0;
      end else if (!refresh_req_i || aref_i) begin
         ref_wait <= '0;
      end else begin
         ref_wait <= ref_wait + 1'b1;
      end
   end

   ack_onehot: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      $onehot0(ack_i)) else $error("ack to more than one port");

   ack_to_requester: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      (ack_i & ~req_i) == '0) else $error("ack to a port without request");

   no_drive_on_read: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      !(dq_oe_i && {ras_i, cas_i, we_i} == cmd_read)) else $error("dq driven on read");

   refresh_served: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      ref_wait <= (REF_W + 1)'(REF_INTERVAL)) else $error("refresh request not served");

endmodule

bind sdr_ctrl_top sdr_ctrl_assert sdr_ctrl_assert_inst (
   .sdram_clk     (sdram_clk),
   .sdram_rst     (sdram_rst),
   .req_i         (req_i),
   .ack_i         (ack_o),
   .ras_i         (ras_pad_o),
   .cas_i         (cas_pad_o),
   .we_i          (we_pad_o),
   .dq_oe_i       (dq_oe_o),
   .refresh_req_i (refresh_req),
   .aref_i        (aref)
);

/* bench/tb_sdr_ctrl.sv */
`timescale 1ns/1ps

module tb_sdr_ctrl;
   import sdr_ctrl_pkg::*;

   // jedec {ras, cas, we} encodings
   localparam logic [2:0] PAD_NOP = 3'b111;
   localparam logic [2:0] PAD_ACT = 3'b011;
   localparam logic [2:0] PAD_RD = 3'b101;
   localparam logic [2:0] PAD_WR = 3'b100;
   localparam logic [2:0] PAD_PRE = 3'b010;
   localparam logic [2:0] PAD_REF = 3'b001;
   localparam int ACK_TIMEOUT = 200;
   localparam int KEY_W = BA_W + 2 * ROW_W;

   logic                      sdram_clk;
   logic                      sdram_rst;
   port_sel_t                 req;
   logic [NUM_PORTS-1:0]      we;
   word_adr_t [NUM_PORTS-1:0] adr;
   word_t [NUM_PORTS-1:0]     wdat;
   bsel_t [NUM_PORTS-1:0]     sel;
   port_sel_t                 ack;
   word_t                     rdat;
   logic [BA_W-1:0]           ba_pad;
   logic [ROW_W-1:0]          a_pad;
   logic                      cs_n_pad;
   logic                      ras_pad;
   logic                      cas_pad;
   logic                      we_pad;
   logic                      cke_pad;
   logic [DQM_W-1:0]          dqm_pad;
   logic [DQ_W-1:0]           dq_out;
   logic [DQ_W-1:0]           dq_in = '0;
   logic                      dq_oe;

   // half-words of the sdram model keyed by {bank, row, column}
   logic [DQ_W-1:0]  mem [logic [KEY_W-1:0]];
   logic [ROW_W-1:0] open_row [1 << BA_W];
   logic [DQ_W-1:0]  rd_sched [int];
   logic             wr_second = 1'b0;
   logic [KEY_W-1:0] wr_key;
   int               cyc = 0;
   int               last_rd_cyc = 0;
   int               aref_cnt = 0;

   word_t                 expect_mem [word_adr_t];
   logic [PORT_W-1:0]     ack_order [$];
   word_t                 last_rdat = '0;
   string                 cur_test = "";
   int                    err_cnt = 0;
   int                    check_cnt = 0;
   int                    test_cnt = 0;
   logic [31:0]           lcg_state = 32'h6997f0ce;

   sdr_ctrl_top sdr_ctrl_top_inst (
      .sdram_clk  (sdram_clk),
      .sdram_rst  (sdram_rst),
      .req_i      (req),
      .we_i       (we),
      .adr_i      (adr),
      .wdat_i     (wdat),
      .sel_i      (sel),
      .ack_o      (ack),
      .rdat_o     (rdat),
      .ba_pad_o   (ba_pad),
      .a_pad_o    (a_pad),
      .cs_n_pad_o (cs_n_pad),
      .ras_pad_o  (ras_pad),
      .cas_pad_o  (cas_pad),
      .we_pad_o   (we_pad),
      .cke_pad_o  (cke_pad),
      .dqm_pad_o  (dqm_pad),
      .dq_o       (dq_out),
      .dq_i       (dq_in),
      .dq_oe_o    (dq_oe)
   );

   initial begin
      sdram_clk = 1'b0;
      forever #2 sdram_clk = ~sdram_clk;
   end

   function automatic logic [31:0] lcg(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [DQ_W-1:0] mem_read(input logic [KEY_W-1:0] key);
      return mem.exists(key) ? mem[key] : '0;
   endfunction

   // dqm high masks the byte
   task automatic mem_write(input logic [KEY_W-1:0] key, input logic [DQ_W-1:0] d,
                            input logic [DQM_W-1:0] m);
      logic [DQ_W-1:0] w;
      w = mem_read(key);
      for (int b = 0; b < DQM_W; b++) begin
         if (!m[b]) begin
            w[8*b +: 8] = d[8*b +: 8];
         end
      end
      mem[key] = w;
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      check_cnt++;
      if (expected !== actual) begin
         err_cnt++;
         $display("** Error [%s] %s: expected %h, actual %h", cur_test, name, expected,
                  actual);
      end
   endtask

   // decode pad commands mid-cycle where they are stable
   always @(negedge sdram_clk) begin
      if (wr_second) begin
         check_value("dq_oe on second write beat", 32'd1, 32'(dq_oe));
         mem_write(wr_key + KEY_W'(1), dq_out, dqm_pad);
      end
      wr_second = 1'b0;
      case ({ras_pad, cas_pad, we_pad})
         PAD_ACT: open_row[ba_pad] = a_pad;
         PAD_WR: begin
            check_value("dq_oe on first write beat", 32'd1, 32'(dq_oe));
            wr_key = {ba_pad, open_row[ba_pad], a_pad};
            mem_write(wr_key, dq_out, dqm_pad);
            wr_second = 1'b1;
         end
         PAD_RD: begin
            rd_sched[cyc + CAS_LAT] = mem_read({ba_pad, open_row[ba_pad], a_pad});
            rd_sched[cyc + CAS_LAT + 1] = mem_read({ba_pad, open_row[ba_pad], a_pad + 1'b1});
            last_rd_cyc = cyc;
         end
         PAD_REF: aref_cnt++;
         default: ;
      endcase
   end

   // read beats land CAS_LAT cycles after the read command
   always @(posedge sdram_clk) begin
      cyc <= cyc + 1;
      dq_in <= rd_sched.exists(cyc + 1) ? rd_sched[cyc + 1] : '0;
   end

   function automatic word_t expect_word(input word_adr_t a);
      return expect_mem.exists(a) ? expect_mem[a] : '0;
   endfunction

   task automatic expect_merge(input word_adr_t a, input word_t d, input bsel_t s);
      word_t w;
      w = expect_word(a);
      for (int b = 0; b < 4; b++) begin
         if (s[b]) begin
            w[8*b +: 8] = d[8*b +: 8];
         end
      end
      expect_mem[a] = w;
   endtask

   // hold the request until the ack pulse and drop it one cycle later
   task automatic access(input logic [PORT_W-1:0] p, input logic wr, input word_adr_t a,
                         input word_t d, input bsel_t s);
      int n;
      @(posedge sdram_clk);
      req[p] <= 1'b1;
      we[p] <= wr;
      adr[p] <= a;
      wdat[p] <= d;
      sel[p] <= s;
      n = 0;
      do begin
         @(negedge sdram_clk);
         n++;
      end while (!ack[p] && n < ACK_TIMEOUT);
      if (!ack[p]) begin
         err_cnt++;
         $display("port %0d got no ack within %0d cycles", p, ACK_TIMEOUT);
      end else if (wr) begin
         check_value("write ack with precharge", 32'(PAD_PRE), 32'({ras_pad, cas_pad, we_pad}));
         expect_merge(a, d, s);
         ack_order.push_back(p);
      end else begin
         last_rdat = rdat;
         check_value("read ack latency", RD_DELAY, cyc - last_rd_cyc);
         check_value($sformatf("read port %0d adr %h", p, a), expect_word(a), rdat);
      end
      @(posedge sdram_clk);
      req[p] <= 1'b0;
   endtask

   task automatic finish_test(input string name, input int errs_before);
      test_cnt++;
      $display("test %s finished with %0d errors", name, err_cnt - errs_before);
   endtask

   task automatic test_reset();
      cur_test = "reset";
      @(negedge sdram_clk);
      check_value("reset ack", 32'd0, 32'(ack));
      check_value("reset dq_oe", 32'd0, 32'(dq_oe));
      check_value("reset command", 32'(PAD_NOP), 32'({ras_pad, cas_pad, we_pad}));
      check_value("reset cs_n and cke", 32'd1, 32'({cs_n_pad, cke_pad}));
      finish_test("reset", 0);
   endtask

   task automatic test_single();
      int e0;
      e0 = err_cnt;
      cur_test = "single write and read";
      access(2'd0, 1'b1, 23'h02a35, 32'hcafe_0123, 4'hf);
      access(2'd0, 1'b0, 23'h02a35, '0, '0);
      finish_test("single write and read", e0);
   endtask

   task automatic test_byte_mask();
      int e0;
      e0 = err_cnt;
      cur_test = "byte mask";
      access(2'd1, 1'b1, 23'h15a07, 32'h1122_3344, 4'hf);
      access(2'd1, 1'b1, 23'h15a07, 32'haabb_ccdd, 4'b1010);
      access(2'd1, 1'b0, 23'h15a07, '0, '0);
      check_value("merged word", 32'haa22_cc44, last_rdat);
      finish_test("byte mask", e0);
   endtask

   task automatic test_arbitration();
      int e0;
      e0 = err_cnt;
      cur_test = "arbitration";
      ack_order.delete();
      fork
         access(2'd0, 1'b1, 23'h001210, 32'h0000_a5a5, 4'hf);
         access(2'd1, 1'b1, 23'h201210, 32'h1111_5a5a, 4'hf);
         access(2'd2, 1'b1, 23'h401210, 32'h2222_c3c3, 4'hf);
         access(2'd3, 1'b1, 23'h601210, 32'h3333_3c3c, 4'hf);
      join
      check_value("ack count", 32'd4, ack_order.size());
      for (int n = 0; n < ack_order.size(); n++) begin
         check_value("ack order", n, 32'(ack_order[n]));
      end
      access(2'd0, 1'b0, 23'h001210, '0, '0);
      access(2'd1, 1'b0, 23'h201210, '0, '0);
      access(2'd2, 1'b0, 23'h401210, '0, '0);
      access(2'd3, 1'b0, 23'h601210, '0, '0);
      finish_test("arbitration", e0);
   endtask

   task automatic test_refresh();
      int e0;
      int n;
      e0 = err_cnt;
      cur_test = "refresh";
      n = aref_cnt;
      repeat (640) @(posedge sdram_clk);
      n = aref_cnt - n;
      check_value("auto refresh count 9 to 10", 32'd1, 32'(n >= 9 && n <= 10));
      finish_test("refresh", e0);
   endtask

   task automatic test_random();
      int          e0;
      word_adr_t   used [$];
      word_adr_t   a;
      word_t       d;
      logic [31:0] r;
      e0 = err_cnt;
      cur_test = "random traffic";
      for (int i = 0; i < 40; i++) begin
         lcg_state = lcg(lcg_state);
         r = lcg_state;
         lcg_state = lcg(lcg_state);
         d = lcg_state;
         if (used.size() == 0 || r[31]) begin
            a = r[ADR_W-1:0];
            used.push_back(a);
            access(r[28:27], 1'b1, a, d, r[26:23]);
         end else begin
            a = used[r[22:0] % used.size()];
            access(r[28:27], 1'b0, a, '0, '0);
         end
      end
      finish_test("random traffic", e0);
   endtask

   initial begin
      sdram_rst = 1'b1;
      req = '0;
      we = '0;
      adr = '0;
      wdat = '0;
      sel = '0;
      repeat (3) @(posedge sdram_clk);
      sdram_rst <= 1'b0;
      test_reset();
      test_single();
      test_byte_mask();
      test_arbitration();
      test_refresh();
      test_random();
      $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* vlog.f */
verilog/sdr_ctrl_pkg.sv
verilog/port_arbiter.sv
verilog/refresh_timer.sv
verilog/sdr_cmd_fsm.sv
verilog/latency_delay.sv
verilog/sdr_data_path.sv
verilog/sdr_ctrl_top.sv
bench/sdr_ctrl_assert.sv
bench/tb_sdr_ctrl.sv

/* Makefile */
SIM = obj_dir/Vtb_sdr_ctrl

.PHONY: run clean

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^RESULT: PASS$$" sim.log

$(SIM): vlog.f $(wildcard verilog/*.sv) $(wildcard bench/*.sv)
	verilator --binary --timing --assert --top-module tb_sdr_ctrl -f vlog.f

clean:
	rm -rf obj_dir sim.log
